// ==== all.f ====
+incdir+sim
common/shuffle_pkg.sv
common/shuffle_req_if.sv
regs/apb_shuffle_regs.sv
shuffle/vec_shuffle_unit.sv
shuffle/shuffle_result_stage.sv
rtl/shuffle_top.sv
sim/tb_shuffle_top.sv

// ==== common/shuffle_pkg.sv ====
`default_nettype none

package shuffle_pkg;

  // --------------------
  // Formats and widths
  // --------------------

  // Source format of the packed operands
  typedef enum logic [1:0] {
    FP32    = 2'd0,
    FP16    = 2'd1,
    FP8     = 2'd2,
    FP16ALT = 2'd3
  } fmt_e;

  localparam int unsigned FLEN_MAX    = 64;
  localparam int unsigned TAG_W       = 7;
  localparam int unsigned APB_AW      = 8;
  localparam int unsigned REG_W       = 32;
  localparam int unsigned LANE_CTRL_W = 32;

  // CTRL register layout
  localparam int unsigned CTRL_W       = 10;
  localparam int unsigned CTRL_MIX_BIT = 2;
  localparam int unsigned CTRL_TAG_LSB = 3;

  // Same vector word read as 32, 16 or 8 bit lanes
  typedef union packed {
    logic [1:0][31:0] w32;
    logic [3:0][15:0] w16;
    logic [7:0][7:0]  w8;
  } vec_u;

  // --------------------
  // Register map
  // --------------------

  // Operands and lane control
  localparam logic [APB_AW-1:0] ADDR_OP1_LO = 8'h00;
  localparam logic [APB_AW-1:0] ADDR_OP1_HI = 8'h04;
  localparam logic [APB_AW-1:0] ADDR_OP2_LO = 8'h08;
  localparam logic [APB_AW-1:0] ADDR_OP2_HI = 8'h0C;
  localparam logic [APB_AW-1:0] ADDR_MASK   = 8'h10;

  // Control, launch and status
  localparam logic [APB_AW-1:0] ADDR_CTRL   = 8'h14;
  localparam logic [APB_AW-1:0] ADDR_START  = 8'h18;
  localparam logic [APB_AW-1:0] ADDR_STATUS = 8'h1C;

  // Result words, read only
  localparam logic [APB_AW-1:0] ADDR_RES_LO = 8'h20;
  localparam logic [APB_AW-1:0] ADDR_RES_HI = 8'h24;

endpackage

`default_nettype wire

// ==== common/shuffle_req_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface shuffle_req_if #(
  parameter int unsigned FLEN = 64
) ();

  // Request side
  logic [FLEN-1:0]                     op1;
  logic [FLEN-1:0]                     op2;
  logic [shuffle_pkg::LANE_CTRL_W-1:0] lane_ctrl;
  shuffle_pkg::fmt_e                   fmt;
  logic                                mix;
  logic [shuffle_pkg::TAG_W-1:0]       tag;
  logic                                req_valid;
  logic                                req_ready;

  // Result side
  logic [FLEN-1:0]                     result;
  logic [shuffle_pkg::TAG_W-1:0]       res_tag;
  logic                                res_valid;
  logic                                res_ready;

  modport regs_mp (
    output op1, op2, lane_ctrl, fmt, mix, tag, req_valid, res_ready,
    input  req_ready, result, res_tag, res_valid
  );

  // Operand fields consumed by the lane selection
  modport shuf_mp (
    input op1, op2, lane_ctrl, fmt, mix
  );

  modport stage_mp (
    input  tag, req_valid, res_ready,
    output req_ready, result, res_tag, res_valid
  );

endinterface

`default_nettype wire

// ==== regs/apb_shuffle_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module apb_shuffle_regs #(
  parameter int unsigned FLEN = 64
) (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  // APB slave
  input  logic                              psel_i,
  input  logic                              penable_i,
  input  logic                              pwrite_i,
  input  logic [shuffle_pkg::APB_AW-1:0]    paddr_i,
  input  logic [shuffle_pkg::REG_W-1:0]     pwdata_i,
  output logic [shuffle_pkg::REG_W-1:0]     prdata_o,
  output logic                              pready_o,
  output logic                              pslverr_o,
  // Request towards the shuffle path
  shuffle_req_if.regs_mp                    req_if
);

  localparam int unsigned RW = shuffle_pkg::REG_W;

  logic [shuffle_pkg::FLEN_MAX-1:0] op1_q;
  logic [shuffle_pkg::FLEN_MAX-1:0] op2_q;
  logic [shuffle_pkg::FLEN_MAX-1:0] res_q;
  logic [RW-1:0]                    mask_q;
  logic [shuffle_pkg::CTRL_W-1:0]   ctrl_q;
  logic [shuffle_pkg::TAG_W-1:0]    res_tag_q;
  logic                             req_valid_q;
  logic                             busy_q;
  logic                             done_q;

  logic          access;
  logic          addr_ok;
  logic          read_only;
  logic          start_hit;
  logic          err;
  logic          wr_en;
  logic          start_wr;
  logic          rd_res_hi;
  logic          res_take;
  logic [RW-1:0] status_word;

  // --------------------
  // APB decode
  // --------------------

  // No wait states
  assign pready_o = 1'b1;
  assign access   = psel_i & penable_i;

  assign status_word = {{(RW - shuffle_pkg::TAG_W - 2){1'b0}}, res_tag_q, done_q, busy_q};

  always_comb begin
    prdata_o  = '0;
    addr_ok   = 1'b1;
    read_only = 1'b0;
    start_hit = 1'b0;
    case (paddr_i)
      shuffle_pkg::ADDR_OP1_LO: prdata_o = op1_q[0 +: RW];
      shuffle_pkg::ADDR_OP1_HI: prdata_o = op1_q[RW +: RW];
      shuffle_pkg::ADDR_OP2_LO: prdata_o = op2_q[0 +: RW];
      shuffle_pkg::ADDR_OP2_HI: prdata_o = op2_q[RW +: RW];
      shuffle_pkg::ADDR_MASK:   prdata_o = mask_q;
      shuffle_pkg::ADDR_CTRL:   prdata_o = {{(RW - shuffle_pkg::CTRL_W){1'b0}}, ctrl_q};
      // Write only, reads as zero
      shuffle_pkg::ADDR_START:  start_hit = 1'b1;
      shuffle_pkg::ADDR_STATUS: begin
        prdata_o  = status_word;
        read_only = 1'b1;
      end
      shuffle_pkg::ADDR_RES_LO: begin
        prdata_o  = res_q[0 +: RW];
        read_only = 1'b1;
      end
      shuffle_pkg::ADDR_RES_HI: begin
        prdata_o  = res_q[RW +: RW];
        read_only = 1'b1;
      end
      default: addr_ok = 1'b0;
    endcase
  end

  assign err = ~addr_ok | (pwrite_i & read_only) | (pwrite_i & start_hit & busy_q);
  assign pslverr_o = access & err;

  assign wr_en     = access & pwrite_i & ~err;
  assign start_wr  = wr_en & start_hit;
  assign rd_res_hi = access & ~pwrite_i & (paddr_i == shuffle_pkg::ADDR_RES_HI);

  // --------------------
  // Register storage
  // --------------------

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      case (paddr_i)
        shuffle_pkg::ADDR_OP1_LO: op1_q[0 +: RW]  <= pwdata_i;
        shuffle_pkg::ADDR_OP1_HI: op1_q[RW +: RW] <= pwdata_i;
        shuffle_pkg::ADDR_OP2_LO: op2_q[0 +: RW]  <= pwdata_i;
        shuffle_pkg::ADDR_OP2_HI: op2_q[RW +: RW] <= pwdata_i;
        shuffle_pkg::ADDR_MASK:   mask_q          <= pwdata_i;
        default: ;
      endcase
    end
    if (res_take) begin
      res_q <= shuffle_pkg::FLEN_MAX'(req_if.result);
    end
  end

  // Control state and launch/complete tracking
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ctrl_q      <= '0;
      res_tag_q   <= '0;
      req_valid_q <= 1'b0;
      busy_q      <= 1'b0;
      done_q      <= 1'b0;
    end else begin
      if (wr_en && paddr_i == shuffle_pkg::ADDR_CTRL) begin
        ctrl_q <= pwdata_i[shuffle_pkg::CTRL_W-1:0];
      end
      // Held until the shuffle path takes it
      if (start_wr) begin
        req_valid_q <= 1'b1;
      end else if (req_valid_q && req_if.req_ready) begin
        req_valid_q <= 1'b0;
      end
      if (start_wr) begin
        busy_q <= 1'b1;
      end else if (res_take) begin
        busy_q <= 1'b0;
      end
      if (res_take) begin
        done_q    <= 1'b1;
        res_tag_q <= req_if.res_tag;
      end else if (rd_res_hi) begin
        done_q <= 1'b0;
      end
    end
  end

  // --------------------
  // Request drive
  // --------------------

  assign req_if.op1       = op1_q[FLEN-1:0];
  assign req_if.op2       = op2_q[FLEN-1:0];
  assign req_if.lane_ctrl = mask_q;
  assign req_if.fmt       = shuffle_pkg::fmt_e'(ctrl_q[1:0]);
  assign req_if.mix       = ctrl_q[shuffle_pkg::CTRL_MIX_BIT];
  assign req_if.tag       = ctrl_q[shuffle_pkg::CTRL_TAG_LSB +: shuffle_pkg::TAG_W];
  assign req_if.req_valid = req_valid_q;

  // Pending result blocks the next one
  assign req_if.res_ready = ~done_q;
  assign res_take         = req_if.res_valid & req_if.res_ready;

endmodule

`default_nettype wire

// ==== rtl/shuffle_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module shuffle_top #(
  parameter int unsigned FLEN = 64
) (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  // APB slave port
  input  logic                            psel_i,
  input  logic                            penable_i,
  input  logic                            pwrite_i,
  input  logic [shuffle_pkg::APB_AW-1:0]  paddr_i,
  input  logic [shuffle_pkg::REG_W-1:0]   pwdata_i,
  output logic [shuffle_pkg::REG_W-1:0]   prdata_o,
  output logic                            pready_o,
  output logic                            pslverr_o
);

  shuffle_req_if #(.FLEN(FLEN)) req_if ();

  shuffle_pkg::vec_u op1_vec;
  shuffle_pkg::vec_u op2_vec;
  logic [FLEN-1:0]   shuf_result;

  // --------------------
  // Register block
  // --------------------

  apb_shuffle_regs #(
    .FLEN (FLEN)
  ) u_regs (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .paddr_i   (paddr_i),
    .pwdata_i  (pwdata_i),
    .prdata_o  (prdata_o),
    .pready_o  (pready_o),
    .pslverr_o (pslverr_o),
    .req_if    (req_if.regs_mp)
  );

  // --------------------
  // Shuffle path
  // --------------------

  // Operands widened to the full union, upper lanes zero for FLEN 32
  assign op1_vec = shuffle_pkg::FLEN_MAX'(req_if.op1);
  assign op2_vec = shuffle_pkg::FLEN_MAX'(req_if.op2);

  vec_shuffle_unit #(
    .FLEN (FLEN)
  ) u_shuffle (
    .op1_i       (op1_vec),
    .op2_i       (op2_vec),
    .lane_ctrl_i (req_if.lane_ctrl),
    .fmt_i       (req_if.fmt),
    .mix_i       (req_if.mix),
    .result_o    (shuf_result)
  );

  shuffle_result_stage #(
    .FLEN (FLEN)
  ) u_stage (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .result_i (shuf_result),
    .req_if   (req_if.stage_mp)
  );

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the shuffle accelerator testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

TOP=tb_shuffle_top
BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module "$TOP" -f all.f > "$BUILD_LOG" 2>&1
build_status=$?
if [ $build_status -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "Verilator build failed with status $build_status"
  exit 1
fi

./obj_dir/V"$TOP" > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "Test failed" "$SIM_LOG"; then
  echo "Failure reported in $SIM_LOG"
  exit 1
fi

echo "No failure reported in $SIM_LOG"
exit 0

// ==== shuffle/shuffle_result_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module shuffle_result_stage #(
  parameter int unsigned FLEN = 64
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  // Shuffle result of the current request
  input  logic [FLEN-1:0]  result_i,
  shuffle_req_if.stage_mp  req_if
);

  logic                          full_q;
  logic [FLEN-1:0]               data_q;
  logic [shuffle_pkg::TAG_W-1:0] tag_q;
  logic                          accept;
  logic                          hand_off;

  // --------------------
  // Handshake
  // --------------------

  // Free when empty or when the entry leaves this cycle
  assign req_if.req_ready = ~full_q | req_if.res_ready;
  assign accept           = req_if.req_valid & req_if.req_ready;
  assign hand_off         = full_q & req_if.res_ready;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      full_q <= 1'b0;
    end else if (accept) begin
      full_q <= 1'b1;
    end else if (hand_off) begin
      full_q <= 1'b0;
    end
  end

  // --------------------
  // Entry payload
  // --------------------

  always_ff @(posedge clk_i) begin
    if (accept) begin
      data_q <= result_i;
      tag_q  <= req_if.tag;
    end
  end

  assign req_if.res_valid = full_q;
  assign req_if.result    = data_q;
  assign req_if.res_tag   = tag_q;

endmodule

`default_nettype wire

// ==== shuffle/vec_shuffle_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module vec_shuffle_unit #(
  parameter int unsigned FLEN = 64
) (
  input  shuffle_pkg::vec_u                    op1_i,
  input  shuffle_pkg::vec_u                    op2_i,
  input  logic [shuffle_pkg::LANE_CTRL_W-1:0]  lane_ctrl_i,
  input  shuffle_pkg::fmt_e                    fmt_i,
  input  logic                                 mix_i,
  output logic [FLEN-1:0]                      result_o
);

  localparam int unsigned NUM_CTRL = FLEN / 8;

  // --------------------
  // Lane control
  // --------------------

  // One nibble per 8 bit lane: index in [2:0], source select in [3]
  logic [NUM_CTRL-1:0][2:0] lane_idx;
  logic [NUM_CTRL-1:0]      lane_sel;

  for (genvar i = 0; i < NUM_CTRL; i++) begin : gen_ctrl
    assign lane_idx[i] = lane_ctrl_i[i*4 +: 3];
    assign lane_sel[i] = lane_ctrl_i[i*4 + 3] & mix_i;
  end

  // --------------------
  // Lane selection
  // --------------------

  logic [FLEN-1:0] res_w32;
  logic [FLEN-1:0] res_w16;
  logic [FLEN-1:0] res_w8;

  // A width is only a vector when it gives at least two lanes
  if (FLEN >= 64) begin : gen_w32
    localparam int unsigned NL = FLEN / 32;
    localparam int unsigned IW = $clog2(NL);
    for (genvar i = 0; i < NL; i++) begin : gen_lane
      logic [IW-1:0] idx;
      // Low index bits, so the index wraps modulo the lane count
      assign idx = lane_idx[i][IW-1:0];
      assign res_w32[i*32 +: 32] = lane_sel[i] ? op2_i.w32[idx] : op1_i.w32[idx];
    end
  end else begin : gen_no_w32
    assign res_w32 = '0;
  end

  if (FLEN >= 32) begin : gen_w16
    localparam int unsigned NL = FLEN / 16;
    localparam int unsigned IW = $clog2(NL);
    for (genvar i = 0; i < NL; i++) begin : gen_lane
      logic [IW-1:0] idx;
      assign idx = lane_idx[i][IW-1:0];
      assign res_w16[i*16 +: 16] = lane_sel[i] ? op2_i.w16[idx] : op1_i.w16[idx];
    end
  end else begin : gen_no_w16
    assign res_w16 = '0;
  end

  if (FLEN >= 16) begin : gen_w8
    localparam int unsigned NL = FLEN / 8;
    localparam int unsigned IW = $clog2(NL);
    for (genvar i = 0; i < NL; i++) begin : gen_lane
      logic [IW-1:0] idx;
      assign idx = lane_idx[i][IW-1:0];
      assign res_w8[i*8 +: 8] = lane_sel[i] ? op2_i.w8[idx] : op1_i.w8[idx];
    end
  end else begin : gen_no_w8
    assign res_w8 = '0;
  end

  // Source format picks the lane width
  always_comb begin
    unique case (fmt_i)
      shuffle_pkg::FP32: begin
        result_o = res_w32;
      end
      shuffle_pkg::FP16,
      shuffle_pkg::FP16ALT: begin
        result_o = res_w16;
      end
      shuffle_pkg::FP8: begin
        result_o = res_w8;
      end
      default: result_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== sim/tb_shuffle_model.svh ====
`ifndef TB_SHUFFLE_MODEL_SVH
`define TB_SHUFFLE_MODEL_SVH

// --------------------
// Reference model
// --------------------

// Expected shuffle of two 64-bit source words
function automatic logic [63:0] model_shuffle(
  input logic [63:0] op1,
  input logic [63:0] op2,
  input logic [31:0] ctrl,
  input logic [1:0]  fmt,
  input logic        mix
);
  int unsigned w;
  int unsigned nl;
  int unsigned idx;
  logic [3:0]  nib;
  logic [63:0] src;
  logic [63:0] lane_mask;
  logic [63:0] res;
  // FP32 gives 32-bit lanes, FP8 8-bit lanes, both FP16 kinds 16-bit lanes
  w = (fmt == 2'd0) ? 32 : ((fmt == 2'd2) ? 8 : 16);
  nl = 64 / w;
  lane_mask = (64'd1 << w) - 64'd1;
  res = '0;
  for (int i = 0; i < nl; i++) begin
    nib = ctrl[i*4 +: 4];
    idx = nib[2:0] % nl;
    src = (mix && nib[3]) ? op2 : op1;
    res = res | (((src >> (idx * w)) & lane_mask) << (i * w));
  end
  return res;
endfunction

// --------------------
// APB master
// --------------------

// One APB3 transfer, response sampled mid-cycle in the access phase
task automatic apb_xfer(
  input  logic        wr,
  input  logic [7:0]  addr,
  input  logic [31:0] wdata,
  output logic [31:0] rdata,
  output logic        err
);
  int unsigned waits;
  waits = 0;
  rdata = '0;
  err   = 1'b0;
  @(posedge clk);
  psel    <= 1'b1;
  penable <= 1'b0;
  pwrite  <= wr;
  paddr   <= addr;
  pwdata  <= wdata;
  @(posedge clk);
  penable <= 1'b1;
  @(negedge clk);
  while (!pready && waits < APB_WAIT_MAX) begin
    @(negedge clk);
    waits++;
  end
  if (!pready) begin
    $display("APB transfer to address %h never saw PREADY", addr);
    timeout_count++;
    finish_run();
  end else begin
    rdata = prdata;
    err   = pslverr;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  end
endtask

`endif

// ==== sim/tb_shuffle_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_shuffle_top;

  localparam int unsigned APB_WAIT_MAX = 16;
  localparam int unsigned POLL_MAX     = 20;
  localparam int unsigned NUM_SHUFFLES = 200;

  logic        clk;
  logic        rst_n;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [7:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;

  int          seed;
  int unsigned error_count;
  int unsigned timeout_count;

  shuffle_top #(
    .FLEN (64)
  ) dut_i (
    .clk_i     (clk),
    .rst_n_i   (rst_n),
    .psel_i    (psel),
    .penable_i (penable),
    .pwrite_i  (pwrite),
    .paddr_i   (paddr),
    .pwdata_i  (pwdata),
    .prdata_o  (prdata),
    .pready_o  (pready),
    .pslverr_o (pslverr)
  );

  `include "tb_shuffle_model.svh"

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // --------------------
  // Reporting
  // --------------------

  task automatic finish_run();
    $display("Errors: %0d, timeouts: %0d", error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  endtask

  task automatic check_eq(input string what, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp) else begin
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
      error_count++;
    end
  endtask

  // --------------------
  // Register access
  // --------------------

  task automatic write_reg(input logic [7:0] addr, input logic [31:0] data, input logic exp_err);
    logic [31:0] unused_rd;
    logic        err;
    apb_xfer(1'b1, addr, data, unused_rd, err);
    check_eq($sformatf("pslverr on write to %h", addr), 64'(err), 64'(exp_err));
  endtask

  task automatic read_reg(input logic [7:0] addr, input logic exp_err, output logic [31:0] data);
    logic err;
    apb_xfer(1'b0, addr, 32'd0, data, err);
    check_eq($sformatf("pslverr on read of %h", addr), 64'(err), 64'(exp_err));
  endtask

  task automatic load_operands(input logic [63:0] a, input logic [63:0] b,
                               input logic [31:0] m, input logic [31:0] c);
    write_reg(shuffle_pkg::ADDR_OP1_LO, a[31:0], 1'b0);
    write_reg(shuffle_pkg::ADDR_OP1_HI, a[63:32], 1'b0);
    write_reg(shuffle_pkg::ADDR_OP2_LO, b[31:0], 1'b0);
    write_reg(shuffle_pkg::ADDR_OP2_HI, b[63:32], 1'b0);
    write_reg(shuffle_pkg::ADDR_MASK, m, 1'b0);
    write_reg(shuffle_pkg::ADDR_CTRL, c, 1'b0);
  endtask

  // Poll STATUS until done
  task automatic wait_done(output logic [31:0] st);
    int unsigned polls;
    polls = 0;
    read_reg(shuffle_pkg::ADDR_STATUS, 1'b0, st);
    while (!st[1] && polls < POLL_MAX) begin
      read_reg(shuffle_pkg::ADDR_STATUS, 1'b0, st);
      polls++;
    end
    if (!st[1]) begin
      $display("Timed out waiting for done in STATUS");
      timeout_count++;
      finish_run();
    end
  endtask

  task automatic read_result(output logic [63:0] res);
    logic [31:0] lo;
    logic [31:0] hi;
    read_reg(shuffle_pkg::ADDR_RES_LO, 1'b0, lo);
    read_reg(shuffle_pkg::ADDR_RES_HI, 1'b0, hi);
    res = {hi, lo};
  endtask

  task automatic run_and_check(input logic [63:0] a, input logic [63:0] b, input logic [31:0] m,
                               input logic [31:0] c, output logic [63:0] res);
    logic [31:0] st;
    load_operands(a, b, m, c);
    write_reg(shuffle_pkg::ADDR_START, 32'd1, 1'b0);
    wait_done(st);
    check_eq("status busy", 64'(st[0]), 64'd0);
    check_eq("status tag", 64'(st[8:2]), 64'(c[9:3]));
    read_result(res);
    check_eq("shuffle result", res, model_shuffle(a, b, m, c[1:0], c[2]));
  endtask

  // --------------------
  // Test sequence
  // --------------------

  initial begin
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] res;
    logic [63:0] res_a;
    logic [31:0] m;
    logic [31:0] c;
    logic [31:0] c_a;
    logic [31:0] d;
    logic [31:0] rd;
    logic [31:0] st;
    logic [7:0]  addr;
    seed          = 32'ha09a_1724;
    error_count   = 0;
    timeout_count = 0;
    rst_n   <= 1'b0;
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= '0;
    pwdata  <= '0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;

    // Readback of operand, mask and control registers
    for (int k = 0; k < 6; k++) begin
      addr = shuffle_pkg::ADDR_OP1_LO + 8'(4 * k);
      d = $random(seed);
      write_reg(addr, d, 1'b0);
      read_reg(addr, 1'b0, rd);
      check_eq($sformatf("readback of %h", addr), 64'(rd),
               64'((addr == shuffle_pkg::ADDR_CTRL) ? (d & 32'h3ff) : d));
    end

    repeat (NUM_SHUFFLES) begin
      a = {$random(seed), $random(seed)};
      b = {$random(seed), $random(seed)};
      m = $random(seed);
      c = $random(seed) & 32'h0000_03ff;
      run_and_check(a, b, m, c, res);
    end

    // Mix off with every select bit set
    repeat (20) begin
      a = {$random(seed), $random(seed)};
      b = {$random(seed), $random(seed)};
      m = $random(seed) | 32'h8888_8888;
      c = $random(seed) & 32'h0000_03fb;
      run_and_check(a, b, m, c, res);
      // Both sources op1, so any select gives an op1 lane
      check_eq("mix off takes op1 lanes", res, model_shuffle(a, a, m, c[1:0], 1'b1));
    end

    // Out-of-range indices wrap
    for (int idx = 2; idx < 8; idx++) begin
      a = {$random(seed), $random(seed)};
      b = {$random(seed), $random(seed)};
      m = {8{1'b0, 3'(idx)}};
      run_and_check(a, b, m, {22'd0, 7'(idx), 3'b000}, res);
      check_eq("FP32 index wrap", res, {2{a[(idx % 2) * 32 +: 32]}});
      run_and_check(a, b, m, {22'd0, 7'(idx), 3'b001}, res);
      check_eq("FP16 index wrap", res, {4{a[(idx % 4) * 16 +: 16]}});
    end

    // Illegal accesses
    read_reg(8'h28, 1'b1, rd);
    write_reg(8'h3C, 32'd0, 1'b1);
    write_reg(shuffle_pkg::ADDR_STATUS, 32'hffff_ffff, 1'b1);

    // Result held while a second request waits behind it
    a = {$random(seed), $random(seed)};
    b = {$random(seed), $random(seed)};
    m = $random(seed);
    c_a = $random(seed) & 32'h0000_03ff;
    load_operands(a, b, m, c_a);
    write_reg(shuffle_pkg::ADDR_START, 32'd1, 1'b0);
    wait_done(st);
    res_a = model_shuffle(a, b, m, c_a[1:0], c_a[2]);
    a = {$random(seed), $random(seed)};
    b = {$random(seed), $random(seed)};
    m = $random(seed);
    c = $random(seed) & 32'h0000_03ff;
    c[9:3] = c_a[9:3] + 7'd1;
    load_operands(a, b, m, c);
    write_reg(shuffle_pkg::ADDR_START, 32'd1, 1'b0);
    read_reg(shuffle_pkg::ADDR_STATUS, 1'b0, st);
    check_eq("busy and done with result pending", 64'(st[1:0]), 64'd3);
    write_reg(shuffle_pkg::ADDR_START, 32'd1, 1'b1);
    read_reg(shuffle_pkg::ADDR_STATUS, 1'b0, st);
    check_eq("pending tag", 64'(st[8:2]), 64'(c_a[9:3]));
    read_result(res);
    check_eq("pending result", res, res_a);
    wait_done(st);
    check_eq("second busy", 64'(st[0]), 64'd0);
    check_eq("second tag", 64'(st[8:2]), 64'(c[9:3]));
    read_result(res);
    check_eq("second result", res, model_shuffle(a, b, m, c[1:0], c[2]));

    finish_run();
  end

endmodule

`default_nettype wire
